// ==== hw/decodeStage.sv ====
module decodeStage (
    input  logic                               clk,
    input  logic                               reset,
    input  mipsPkg::instrWord                  instr,
    input  logic [mipsPkg::dataWidth-1:0]      pcNext,
    input  logic                               valid,
    input  logic                               stall,
    input  logic                               flush,
    input  logic                               wbWrite,
    input  logic [mipsPkg::regAddrWidth-1:0]   wbAddr,
    input  logic [mipsPkg::dataWidth-1:0]      wbData,
    output logic [mipsPkg::regAddrWidth-1:0]   exRs,
    output logic [mipsPkg::regAddrWidth-1:0]   exRt,
    output logic [mipsPkg::regAddrWidth-1:0]   exRd,
    output logic [mipsPkg::dataWidth-1:0]      exOperandA,
    output logic [mipsPkg::dataWidth-1:0]      exOperandB,
    output logic [mipsPkg::dataWidth-1:0]      exImm,
    output logic [mipsPkg::dataWidth-1:0]      exPcNext,
    output logic [mipsPkg::dataWidth-1:0]      exJumpTarget,
    output logic                               exRegWrite,
    output logic                               exMemRead,
    output logic                               exMemWrite,
    output logic                               exMemToReg,
    output logic                               exAluSrc,
    output logic                               exRegDst,
    output logic [mipsPkg::aluOpWidth-1:0]     exAluOp,
    output logic                               exBranch,
    output logic                               exJump,
    output logic                               exHalt,
    output logic                               exValid,
    output logic                               haltDecoded
);
    import mipsPkg::*;

    logic [dataWidth-1:0] regFile [32];
    logic [dataWidth-1:0] readA;
    logic [dataWidth-1:0] readB;
    logic [dataWidth-1:0] immExt;
    logic [dataWidth-1:0] jumpTarget;
    logic regWrite;
    logic memRead;
    logic memWrite;
    logic memToReg;
    logic aluSrc;
    logic regDst;
    logic branch;
    logic jump;
    logic halt;
    logic [aluOpWidth-1:0] aluOp;

    // writeback never targets r0, so no guard is needed here
    always_ff @(posedge clk) begin
        if (wbWrite) begin
            regFile[wbAddr] <= wbData;
        end
    end

    // write-through read, r0 hardwired to zero
    function automatic logic [dataWidth-1:0] readReg(input logic [regAddrWidth-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (wbWrite && wbAddr == addr) begin
            return wbData;
        end
        return regFile[addr];
    endfunction

    always_comb begin
        readA = readReg(instr.rFields.rs);
        readB = readReg(instr.rFields.rt);
    end

    assign immExt      = {{16{instr.iFields.imm[15]}}, instr.iFields.imm};
    assign jumpTarget  = {pcNext[31:28], instr.jFields.target, 2'b00};
    assign haltDecoded = halt;

    always_comb begin
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b0;
        aluSrc   = 1'b0;
        regDst   = 1'b0;
        branch   = 1'b0;
        jump     = 1'b0;
        halt     = 1'b0;
        aluOp    = aluAdd;
        if (valid) begin
            case (instr.rFields.op)
                opRType: begin
                    regDst   = 1'b1;
                    regWrite = 1'b1;
                    case (instr.rFields.funct)
                        functAdd: aluOp = aluAdd;
                        functSub: aluOp = aluSub;
                        functAnd: aluOp = aluAnd;
                        functOr:  aluOp = aluOr;
                        functSlt: aluOp = aluSlt;
                        // unknown funct acts as a nop
                        default:  regWrite = 1'b0;
                    endcase
                end
                opAddi: begin
                    regWrite = 1'b1;
                    aluSrc   = 1'b1;
                end
                opLw: begin
                    regWrite = 1'b1;
                    memRead  = 1'b1;
                    memToReg = 1'b1;
                    aluSrc   = 1'b1;
                end
                opSw: begin
                    memWrite = 1'b1;
                    aluSrc   = 1'b1;
                end
                opBeq:   branch = 1'b1;
                opJ:     jump = 1'b1;
                opHalt:  halt = 1'b1;
                default: ;
            endcase
        end
    end

    // ID/EX control, bubble on stall or flush
    always_ff @(posedge clk) begin
        if (reset || stall || flush) begin
            exRegWrite <= 1'b0;
            exMemRead  <= 1'b0;
            exMemWrite <= 1'b0;
            exBranch   <= 1'b0;
            exJump     <= 1'b0;
            exHalt     <= 1'b0;
            exValid    <= 1'b0;
        end else begin
            exRegWrite <= regWrite;
            exMemRead  <= memRead;
            exMemWrite <= memWrite;
            exBranch   <= branch;
            exJump     <= jump;
            exHalt     <= halt;
            exValid    <= valid;
        end
    end

    // ID/EX payload
    always_ff @(posedge clk) begin
        exRs         <= instr.rFields.rs;
        exRt         <= instr.rFields.rt;
        exRd         <= instr.rFields.rd;
        exOperandA   <= readA;
        exOperandB   <= readB;
        exImm        <= immExt;
        exPcNext     <= pcNext;
        exJumpTarget <= jumpTarget;
        exMemToReg   <= memToReg;
        exAluSrc     <= aluSrc;
        exRegDst     <= regDst;
        exAluOp      <= aluOp;
    end

endmodule

// ==== hw/executeStage.sv ====
module executeStage (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [mipsPkg::regAddrWidth-1:0]   exRt,
    input  logic [mipsPkg::regAddrWidth-1:0]   exRd,
    input  logic [mipsPkg::dataWidth-1:0]      exOperandA,
    input  logic [mipsPkg::dataWidth-1:0]      exOperandB,
    input  logic [mipsPkg::dataWidth-1:0]      exImm,
    input  logic [mipsPkg::dataWidth-1:0]      exPcNext,
    input  logic [mipsPkg::dataWidth-1:0]      exJumpTarget,
    input  logic                               exRegWrite,
    input  logic                               exMemRead,
    input  logic                               exMemWrite,
    input  logic                               exMemToReg,
    input  logic                               exAluSrc,
    input  logic                               exRegDst,
    input  logic [mipsPkg::aluOpWidth-1:0]     exAluOp,
    input  logic                               exBranch,
    input  logic                               exJump,
    input  logic                               exHalt,
    input  logic                               exValid,
    input  logic [1:0]                         forwardA,
    input  logic [1:0]                         forwardB,
    input  logic [mipsPkg::dataWidth-1:0]      wbData,
    output logic                               redirect,
    output logic [mipsPkg::dataWidth-1:0]      redirectTarget,
    output logic [mipsPkg::dataWidth-1:0]      memAluResult,
    output logic [mipsPkg::dataWidth-1:0]      memStoreData,
    output logic [mipsPkg::regAddrWidth-1:0]   memDest,
    output logic                               memRegWrite,
    output logic                               memMemRead,
    output logic                               memMemWrite,
    output logic                               memMemToReg,
    output logic                               memHalt
);
    import mipsPkg::*;

    logic [dataWidth-1:0] operandA;
    logic [dataWidth-1:0] operandB;
    logic [dataWidth-1:0] aluB;
    logic [dataWidth-1:0] aluResult;
    logic [regAddrWidth-1:0] dest;

    function automatic logic [dataWidth-1:0] selectOperand(
        input logic [1:0]           sel,
        input logic [dataWidth-1:0] regValue
    );
        case (sel)
            fwdMem:  return memAluResult;
            fwdWb:   return wbData;
            default: return regValue;
        endcase
    endfunction

    always_comb begin
        operandA = selectOperand(forwardA, exOperandA);
        operandB = selectOperand(forwardB, exOperandB);
    end

    assign aluB = exAluSrc ? exImm : operandB;

    always_comb begin
        case (exAluOp)
            aluSub:  aluResult = operandA - aluB;
            aluAnd:  aluResult = operandA & aluB;
            aluOr:   aluResult = operandA | aluB;
            aluSlt:  aluResult = {31'b0, $signed(operandA) < $signed(aluB)};
            default: aluResult = operandA + aluB;
        endcase
    end

    assign dest = exRegDst ? exRd : exRt;

    // beq compares the forwarded registers directly
    assign redirect = exValid && (exJump || (exBranch && operandA == operandB));
    assign redirectTarget = exJump ? exJumpTarget : exPcNext + (exImm << 2);

    // EX/MEM control
    always_ff @(posedge clk) begin
        if (reset) begin
            memRegWrite <= 1'b0;
            memMemRead  <= 1'b0;
            memMemWrite <= 1'b0;
            memHalt     <= 1'b0;
        end else begin
            memRegWrite <= exRegWrite && dest != '0;
            memMemRead  <= exMemRead;
            memMemWrite <= exMemWrite;
            memHalt     <= exHalt;
        end
    end

    // EX/MEM payload
    always_ff @(posedge clk) begin
        memAluResult <= aluResult;
        memStoreData <= operandB;
        memDest      <= dest;
        memMemToReg  <= exMemToReg;
    end

endmodule

// ==== hw/fetchStage.sv ====
module fetchStage (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            stall,
    input  logic                            redirect,
    input  logic [mipsPkg::dataWidth-1:0]   redirectTarget,
    input  logic                            haltDecoded,
    output mipsPkg::instrWord               instr,
    output logic [mipsPkg::dataWidth-1:0]   pcNext,
    output logic                            valid
);
    import mipsPkg::*;

    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] pcPlus4;
    logic [dataWidth-1:0] rom [imemDepth];
    // set once a halt leaves decode, PC stays frozen until reset
    logic halted;

    initial begin
        $readmemh(programFile, rom);
    end

    assign pcPlus4 = pc + 4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= '0;
            halted <= 1'b0;
        end else begin
            if (redirect) begin
                pc <= redirectTarget;
            end else if (!(stall || halted || haltDecoded)) begin
                pc <= pcPlus4;
            end
            // a halt squashed by an older jump must not freeze fetch
            if (haltDecoded && !redirect && !stall) begin
                halted <= 1'b1;
            end
        end
    end

    // IF/ID register
    always_ff @(posedge clk) begin
        if (reset || redirect) begin
            valid <= 1'b0;
        end else if (!stall) begin
            valid  <= !(haltDecoded || halted);
            instr  <= rom[pc[imemAddrWidth+1:2]];
            pcNext <= pcPlus4;
        end
    end

endmodule

// ==== hw/hazardUnit.sv ====
module hazardUnit (
    input  logic [mipsPkg::regAddrWidth-1:0] idRs,
    input  logic [mipsPkg::regAddrWidth-1:0] idRt,
    input  logic [mipsPkg::regAddrWidth-1:0] exRs,
    input  logic [mipsPkg::regAddrWidth-1:0] exRt,
    input  logic                             exMemRead,
    input  logic [mipsPkg::regAddrWidth-1:0] memDest,
    input  logic                             memRegWrite,
    input  logic [mipsPkg::regAddrWidth-1:0] wbDest,
    input  logic                             wbRegWrite,
    output logic                             stall,
    output logic [1:0]                       forwardA,
    output logic [1:0]                       forwardB
);
    import mipsPkg::*;

    // load in execute feeding the instruction in decode
    assign stall = exMemRead && exRt != '0 && (exRt == idRs || exRt == idRt);

    // the younger producer in memory wins over writeback
    function automatic logic [1:0] pickSource(input logic [regAddrWidth-1:0] src);
        if (src == '0) begin
            return fwdReg;
        end
        if (memRegWrite && memDest == src) begin
            return fwdMem;
        end
        if (wbRegWrite && wbDest == src) begin
            return fwdWb;
        end
        return fwdReg;
    endfunction

    always_comb begin
        forwardA = pickSource(exRs);
        forwardB = pickSource(exRt);
    end

endmodule

// ==== hw/memoryStage.sv ====
module memoryStage (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [mipsPkg::dataWidth-1:0]      memAluResult,
    input  logic [mipsPkg::dataWidth-1:0]      memStoreData,
    input  logic [mipsPkg::regAddrWidth-1:0]   memDest,
    input  logic                               memRegWrite,
    input  logic                               memMemRead,
    input  logic                               memMemWrite,
    input  logic                               memMemToReg,
    input  logic                               memHalt,
    output logic                               wbWrite,
    output logic [mipsPkg::regAddrWidth-1:0]   wbAddr,
    output logic [mipsPkg::dataWidth-1:0]      wbData,
    output logic                               fin
);
    import mipsPkg::*;

    logic [dataWidth-1:0] dataMem [dmemDepth];
    logic [dmemAddrWidth-1:0] wordAddr;
    logic [dataWidth-1:0] loadData;
    logic [dataWidth-1:0] wbLoad;
    logic [dataWidth-1:0] wbAlu;
    logic wbMemToReg;

    // byte address to word index
    assign wordAddr = memAluResult[dmemAddrWidth+1:2];
    assign loadData = memMemRead ? dataMem[wordAddr] : '0;

    always_ff @(posedge clk) begin
        if (memMemWrite) begin
            dataMem[wordAddr] <= memStoreData;
        end
    end

    // MEM/WB control, fin is sticky
    always_ff @(posedge clk) begin
        if (reset) begin
            wbWrite <= 1'b0;
            fin     <= 1'b0;
        end else begin
            wbWrite <= memRegWrite;
            if (memHalt) begin
                fin <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        wbAddr     <= memDest;
        wbAlu      <= memAluResult;
        wbLoad     <= loadData;
        wbMemToReg <= memMemToReg;
    end

    assign wbData = wbMemToReg ? wbLoad : wbAlu;

endmodule

// ==== hw/mipsPipeline.sv ====
module mipsPipeline (
    input  logic                               clk,
    input  logic                               reset,
    output logic                               fin,
    output logic                               regWrite,
    output logic [mipsPkg::regAddrWidth-1:0]   regWriteAddr,
    output logic [mipsPkg::dataWidth-1:0]      regWriteData
);
    import mipsPkg::*;

    // fetch and hazard control
    logic stall;
    logic redirect;
    logic haltDecoded;
    logic valid;
    logic [dataWidth-1:0] redirectTarget;
    logic [dataWidth-1:0] pcNext;
    instrWord instr;

    // ID/EX
    logic [regAddrWidth-1:0] exRs;
    logic [regAddrWidth-1:0] exRt;
    logic [regAddrWidth-1:0] exRd;
    logic [dataWidth-1:0] exOperandA;
    logic [dataWidth-1:0] exOperandB;
    logic [dataWidth-1:0] exImm;
    logic [dataWidth-1:0] exPcNext;
    logic [dataWidth-1:0] exJumpTarget;
    logic [aluOpWidth-1:0] exAluOp;
    logic exRegWrite, exMemRead, exMemWrite, exMemToReg;
    logic exAluSrc, exRegDst, exBranch, exJump, exHalt, exValid;
    logic [1:0] forwardA;
    logic [1:0] forwardB;

    // EX/MEM
    logic [dataWidth-1:0] memAluResult;
    logic [dataWidth-1:0] memStoreData;
    logic [regAddrWidth-1:0] memDest;
    logic memRegWrite, memMemRead, memMemWrite, memMemToReg, memHalt;

    fetchStage fetchStage_i (
        .clk(clk), .reset(reset), .stall(stall), .redirect(redirect),
        .redirectTarget(redirectTarget), .haltDecoded(haltDecoded),
        .instr(instr), .pcNext(pcNext), .valid(valid)
    );

    // writeback port doubles as the write trace
    decodeStage decodeStage_i (
        .clk(clk), .reset(reset), .instr(instr), .pcNext(pcNext), .valid(valid),
        .stall(stall), .flush(redirect),
        .wbWrite(regWrite), .wbAddr(regWriteAddr), .wbData(regWriteData),
        .exRs(exRs), .exRt(exRt), .exRd(exRd),
        .exOperandA(exOperandA), .exOperandB(exOperandB), .exImm(exImm),
        .exPcNext(exPcNext), .exJumpTarget(exJumpTarget),
        .exRegWrite(exRegWrite), .exMemRead(exMemRead), .exMemWrite(exMemWrite),
        .exMemToReg(exMemToReg), .exAluSrc(exAluSrc), .exRegDst(exRegDst),
        .exAluOp(exAluOp), .exBranch(exBranch), .exJump(exJump), .exHalt(exHalt),
        .exValid(exValid), .haltDecoded(haltDecoded)
    );

    hazardUnit hazardUnit_i (
        .idRs(instr.rFields.rs), .idRt(instr.rFields.rt),
        .exRs(exRs), .exRt(exRt), .exMemRead(exMemRead),
        .memDest(memDest), .memRegWrite(memRegWrite),
        .wbDest(regWriteAddr), .wbRegWrite(regWrite),
        .stall(stall), .forwardA(forwardA), .forwardB(forwardB)
    );

    executeStage executeStage_i (
        .clk(clk), .reset(reset), .exRt(exRt), .exRd(exRd),
        .exOperandA(exOperandA), .exOperandB(exOperandB), .exImm(exImm),
        .exPcNext(exPcNext), .exJumpTarget(exJumpTarget),
        .exRegWrite(exRegWrite), .exMemRead(exMemRead), .exMemWrite(exMemWrite),
        .exMemToReg(exMemToReg), .exAluSrc(exAluSrc), .exRegDst(exRegDst),
        .exAluOp(exAluOp), .exBranch(exBranch), .exJump(exJump), .exHalt(exHalt),
        .exValid(exValid), .forwardA(forwardA), .forwardB(forwardB),
        .wbData(regWriteData), .redirect(redirect), .redirectTarget(redirectTarget),
        .memAluResult(memAluResult), .memStoreData(memStoreData), .memDest(memDest),
        .memRegWrite(memRegWrite), .memMemRead(memMemRead), .memMemWrite(memMemWrite),
        .memMemToReg(memMemToReg), .memHalt(memHalt)
    );

    memoryStage memoryStage_i (
        .clk(clk), .reset(reset), .memAluResult(memAluResult),
        .memStoreData(memStoreData), .memDest(memDest), .memRegWrite(memRegWrite),
        .memMemRead(memMemRead), .memMemWrite(memMemWrite),
        .memMemToReg(memMemToReg), .memHalt(memHalt),
        .wbWrite(regWrite), .wbAddr(regWriteAddr), .wbData(regWriteData), .fin(fin)
    );

endmodule

// ==== hw/mipsPkg.sv ====
package mipsPkg;

    localparam int dataWidth     = 32;
    localparam int regAddrWidth  = 5;
    localparam int aluOpWidth    = 3;
    localparam int imemDepth     = 256;
    localparam int dmemDepth     = 256;
    localparam int imemAddrWidth = $clog2(imemDepth);
    localparam int dmemAddrWidth = $clog2(dmemDepth);

    localparam string programFile = "tests/program.hex";

    // primary opcodes, 0x3f is unused by MIPS and serves as halt
    localparam logic [5:0] opRType = 6'h00;
    localparam logic [5:0] opJ     = 6'h02;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] opAddi  = 6'h08;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;
    localparam logic [5:0] opHalt  = 6'h3f;

    localparam logic [5:0] functAdd = 6'h20;
    localparam logic [5:0] functSub = 6'h22;
    localparam logic [5:0] functAnd = 6'h24;
    localparam logic [5:0] functOr  = 6'h25;
    localparam logic [5:0] functSlt = 6'h2a;

    localparam logic [aluOpWidth-1:0] aluAdd = 3'd0;
    localparam logic [aluOpWidth-1:0] aluSub = 3'd1;
    localparam logic [aluOpWidth-1:0] aluAnd = 3'd2;
    localparam logic [aluOpWidth-1:0] aluOr  = 3'd3;
    localparam logic [aluOpWidth-1:0] aluSlt = 3'd4;

    // operand source selects for execute
    localparam logic [1:0] fwdReg = 2'b00;
    localparam logic [1:0] fwdWb  = 2'b01;
    localparam logic [1:0] fwdMem = 2'b10;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFormat;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iFormat;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] target;
    } jFormat;

    typedef union packed {
        rFormat rFields;
        iFormat iFields;
        jFormat jFields;
    } instrWord;

endpackage

// ==== run.sh ====
#!/bin/sh
# build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module mipsPipelineTb -o simv
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1

// ==== tests/mipsChecker.sv ====
module mipsChecker #(
    parameter int maxSteps = 256
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             fin,
    input  logic                             regWrite,
    input  logic [mipsPkg::regAddrWidth-1:0] regWriteAddr,
    input  logic [mipsPkg::dataWidth-1:0]    regWriteData,
    output logic                             done,
    output int                               errorCount,
    output int                               testsPassed,
    output int                               testsFailed
);
    timeunit 1ns;
    timeprecision 1ps;
    import mipsPkg::*;

    localparam int numTests = 5;
    localparam int haltTest = 4;

    string testNames [numTests];
    logic [dataWidth-1:0] progMem [imemDepth];
    logic [regAddrWidth-1:0] expAddr [$];
    logic [dataWidth-1:0] expData [$];
    int expTest [$];
    int seen;
    int finCycles;
    int testErrors [numTests];
    bit reported [numTests];

    // test owning the instruction at a word address
    function automatic int testOf(input int wordIndex);
        if (wordIndex <= 6) return 0;
        if (wordIndex <= 9) return 1;
        if (wordIndex <= 15) return 2;
        if (wordIndex <= 19) return 3;
        return haltTest;
    endfunction

    // instruction-level model of the program
    function automatic void runReference();
        logic [dataWidth-1:0] regs [32];
        logic [dataWidth-1:0] mem [dmemDepth];
        logic [dataWidth-1:0] imm;
        logic [dataWidth-1:0] res;
        logic [regAddrWidth-1:0] dst;
        instrWord iw;
        int pc;
        bit writes;
        pc = 0;
        for (int i = 0; i < 32; i++) regs[i] = '0;
        for (int i = 0; i < dmemDepth; i++) mem[i] = '0;
        for (int step = 0; step < maxSteps; step++) begin
            iw = progMem[pc];
            imm = {{16{iw.iFields.imm[15]}}, iw.iFields.imm};
            writes = 1'b0;
            dst = iw.iFields.rt;
            res = '0;
            if (iw.rFields.op == opHalt) break;
            case (iw.rFields.op)
                opRType: begin
                    dst = iw.rFields.rd;
                    writes = 1'b1;
                    case (iw.rFields.funct)
                        functAdd: res = regs[iw.rFields.rs] + regs[iw.rFields.rt];
                        functSub: res = regs[iw.rFields.rs] - regs[iw.rFields.rt];
                        functAnd: res = regs[iw.rFields.rs] & regs[iw.rFields.rt];
                        functOr:  res = regs[iw.rFields.rs] | regs[iw.rFields.rt];
                        functSlt: res = ($signed(regs[iw.rFields.rs]) <
                                         $signed(regs[iw.rFields.rt])) ? 32'd1 : 32'd0;
                        default:  writes = 1'b0;
                    endcase
                end
                opAddi: begin
                    res = regs[iw.iFields.rs] + imm;
                    writes = 1'b1;
                end
                opLw: begin
                    res = regs[iw.iFields.rs] + imm;
                    res = mem[res[9:2]];
                    writes = 1'b1;
                end
                opSw: begin
                    res = regs[iw.iFields.rs] + imm;
                    mem[res[9:2]] = regs[iw.iFields.rt];
                end
                default: ;
            endcase
            if (writes && dst != '0) begin
                regs[dst] = res;
                expAddr.push_back(dst);
                expData.push_back(res);
                expTest.push_back(testOf(pc));
            end
            if (iw.rFields.op == opBeq && regs[iw.iFields.rs] == regs[iw.iFields.rt]) begin
                pc = pc + 1 + $signed(imm);
            end else if (iw.rFields.op == opJ) begin
                pc = int'(iw.jFields.target);
            end else begin
                pc = pc + 1;
            end
        end
    endfunction

    task automatic reportTest(input int t);
        reported[t] = 1'b1;
        if (testErrors[t] == 0) begin
            $display("test %s passed", testNames[t]);
            testsPassed++;
        end else begin
            $display("test %s failed with %0d errors", testNames[t], testErrors[t]);
            testsFailed++;
        end
    endtask

    task automatic checkWrite();
        int t;
        if (finCycles > 0) begin
            $display("register write to r%0d while fin is high", regWriteAddr);
            testErrors[haltTest]++;
            errorCount++;
        end else if (seen >= expAddr.size()) begin
            $display("unexpected extra register write to r%0d", regWriteAddr);
            testErrors[haltTest]++;
            errorCount++;
        end else begin
            t = expTest[seen];
            if (regWriteAddr != expAddr[seen] || regWriteData != expData[seen]) begin
                $display("FAIL %s: expected r%0d=%h, actual r%0d=%h", testNames[t],
                         expAddr[seen], expData[seen], regWriteAddr, regWriteData);
                testErrors[t]++;
                errorCount++;
            end
            seen++;
            if (seen == expAddr.size() || expTest[seen] != t) begin
                reportTest(t);
            end
        end
    endtask

    initial begin
        testNames[0] = "aluDependent";
        testNames[1] = "loadUse";
        testNames[2] = "branchSquash";
        testNames[3] = "jump";
        testNames[4] = "halt";
        done = 1'b0;
        errorCount = 0;
        testsPassed = 0;
        testsFailed = 0;
        for (int t = 0; t < numTests; t++) begin
            testErrors[t] = 0;
            reported[t] = 1'b0;
        end
        $readmemh(programFile, progMem);
        runReference();
    end

    // outputs sampled at the edge hold last cycle's writeback
    always @(posedge clk) begin
        if (reset) begin
            seen = 0;
            finCycles = 0;
        end else if (!done) begin
            // fin stays high once it has risen
            if (fin || finCycles > 0) begin
                if (!fin) begin
                    $display("fin fell low again before reset");
                    testErrors[haltTest]++;
                    errorCount++;
                end
                finCycles++;
                // every expected write must be done before the cycle fin is high
                if (finCycles == 1 && seen != expAddr.size()) begin
                    $display("fin rose after %0d writes, reference expects %0d",
                             seen, expAddr.size());
                    testErrors[haltTest]++;
                    errorCount++;
                end
            end
            if (regWrite) begin
                checkWrite();
            end
            // a few quiet cycles prove no write follows fin
            if (finCycles == 8) begin
                for (int t = 0; t < haltTest; t++) begin
                    if (!reported[t]) begin
                        $display("test %s never saw all of its writes", testNames[t]);
                        testErrors[t]++;
                        errorCount++;
                        reportTest(t);
                    end
                end
                reportTest(haltTest);
                done = 1'b1;
            end
        end
    end

endmodule

// ==== tests/mipsPipelineTb.sv ====
module mipsPipelineTb;
    timeunit 1ns;
    timeprecision 1ps;
    import mipsPkg::*;

    localparam int maxSteps    = 256;
    localparam int resetCycles = 5;
    localparam int timeoutCycles = maxSteps * 3 + 30;

    logic clk;
    logic reset;
    logic fin;
    logic regWrite;
    logic [regAddrWidth-1:0] regWriteAddr;
    logic [dataWidth-1:0] regWriteData;

    logic checkDone;
    int errorCount;
    int testsPassed;
    int testsFailed;

    mipsPipeline mipsPipeline_i (
        .clk(clk),
        .reset(reset),
        .fin(fin),
        .regWrite(regWrite),
        .regWriteAddr(regWriteAddr),
        .regWriteData(regWriteData)
    );

    mipsChecker #(.maxSteps(maxSteps)) checker_i (
        .clk(clk),
        .reset(reset),
        .fin(fin),
        .regWrite(regWrite),
        .regWriteAddr(regWriteAddr),
        .regWriteData(regWriteData),
        .done(checkDone),
        .errorCount(errorCount),
        .testsPassed(testsPassed),
        .testsFailed(testsFailed)
    );

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
    end

    always #5 clk = ~clk;

    // release reset on a rising edge
    initial begin
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;
    end

    initial begin
        wait (checkDone === 1'b1);
        @(posedge clk);
        $display("tests passed %0d, tests failed %0d, errors %0d",
                 testsPassed, testsFailed, errorCount);
        if (errorCount == 0 && testsFailed == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // watchdog sized from the longest program run
    initial begin
        repeat (timeoutCycles) @(posedge clk);
        $display("watchdog timeout: fin never rose");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== tests/program.hex ====
// one 32-bit instruction word per line, word address 0 first
20010005 // addi r1, r0, 5
20220003 // addi r2, r1, 3
00221820 // add  r3, r1, r2
00612022 // sub  r4, r3, r1
00822824 // and  r5, r4, r2
00a13025 // or   r6, r5, r1
0023382a // slt  r7, r1, r3
ac030010 // sw   r3, 16(r0)
8c080010 // lw   r8, 16(r0)
01014820 // add  r9, r8, r1
10220002 // beq  r1, r2, +2 not taken
200a0007 // addi r10, r0, 7
10820002 // beq  r4, r2, +2 taken
200b0063 // addi r11, r0, 99 squashed
200c0063 // addi r12, r0, 99 squashed
200d0001 // addi r13, r0, 1
08000013 // j    19
200e0063 // addi r14, r0, 99 skipped
200f0063 // addi r15, r0, 99 skipped
20100002 // addi r16, r0, 2
fc000000 // halt
20110063 // addi r17, r0, 99 behind halt

// ==== vlog.f ====
hw/mipsPkg.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/hazardUnit.sv
hw/executeStage.sv
hw/memoryStage.sv
hw/mipsPipeline.sv
tests/mipsChecker.sv
tests/mipsPipelineTb.sv
